// ==== include/ps2_mouse_defines.svh ====
/*
 * Fixed PS/2 frame layout, command frame and sequencer timer taps.
 * Include wherever a frame width, byte field or timer bit is needed.
 */
`ifndef PS2_MOUSE_DEFINES_SVH
`define PS2_MOUSE_DEFINES_SVH

// receive frame: start, 8 data, parity, stop
`define PS2_FRAME_BITS    11
`define PS2_DATA_LSB      1                   // first data bit in a frame
`define PS2_DATA_MSB      8                   // last data bit in a frame

// host command frame, lsb first: start, 0xF4, odd parity 0, stop, guard
`define PS2_CMD_BITS      12
`define PS2_CMD_FRAME     12'b1101_1110_1000
`define PS2_CMD_DONE      12'b0000_0000_0001  // only the guard bit left

// sequencer timer
`define MOUSE_TIMER_BITS  16
`define MOUSE_HOLD_BIT    11                  // 2048 cycles of clock hold-off
`define MOUSE_WHEEL_BIT   14                  // 16384 cycles wheel byte wait

`define MOUSE_BTN_BITS    3                   // {middle, right, left}
`define PS2_ACK_BYTE      8'hFA               // mouse reply to a command

`endif

// ==== hdl/ps2_mouse_pkg.sv ====
/*
 * Shared types for the PS/2 mouse controller.
 * Sequencer states and the packet byte tag passed to the accumulator.
 */
package ps2_mouse_pkg;

	// ------------------------------------------------------------------------
	// power-up and packet sequencer states
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		st_init,      // clear timer
		st_hold_clk,  // clock held low, command frame loaded
		st_send_cmd,  // device clocks the command out
		st_wait_ack,  // acknowledge byte, not a delta
		st_byte1,     // buttons
		st_byte2,     // x delta
		st_byte3,     // y delta
		st_byte4      // optional wheel byte
	} mouse_state_e;

	// which received byte is valid this cycle
	typedef enum logic [1:0] {
		pkt_none,
		pkt_buttons,
		pkt_dx,
		pkt_dy
	} pkt_sel_e;

endpackage

// ==== hdl/ps2_rx_shifter.sv ====
/*
 * PS/2 receive side: input synchronizers, clock falling edge strobe
 * and the 11-bit frame shifter. A frame is ready when its start bit is at bit 0.
 */
`timescale 1ns/1ns
`include "ps2_mouse_defines.svh"

module ps2_rx_shifter
(
	input  logic       clk,
	input  logic       mrreset,
	input  logic       ps2_clk_in,   // PS/2 clock pin level
	input  logic       ps2_dat_in,   // PS/2 data pin level
	input  logic       rx_clear,     // refill shifter with ones
	output logic       clk_fall,     // one cycle per PS/2 clock fall
	output logic       rx_ready,     // full frame in shifter
	output logic [7:0] rx_byte       // frame data bits
);

	logic                        clk_s1;    // clock sync stage 1
	logic                        clk_s2;    // clock sync stage 2
	logic                        clk_prev;  // delayed for edge detect
	logic                        dat_s1;    // data sync stage 1
	logic                        dat_s2;    // data sync stage 2
	logic [`PS2_FRAME_BITS-1:0]  rx_shift;  // frame shifter, lsb arrives first

	// ------------------------------------------------------------------------
	// synchronizers, idle lines read high
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			clk_s1   <= 1'b1;
			clk_s2   <= 1'b1;
			clk_prev <= 1'b1;
			dat_s1   <= 1'b1;
			dat_s2   <= 1'b1;
		end
		else
		begin
			clk_s1   <= ps2_clk_in;
			clk_s2   <= clk_s1;
			clk_prev <= clk_s2;
			dat_s1   <= ps2_dat_in;
			dat_s2   <= dat_s1;
		end
	end

	assign clk_fall = clk_prev & ~clk_s2;   // high then low

	// shift in from the top, start bit walks down to bit 0
	always_ff @(posedge clk)
	begin
		if (mrreset || rx_clear)
			rx_shift <= '1;
		else if (clk_fall)
			rx_shift <= {dat_s2, rx_shift[`PS2_FRAME_BITS-1:1]};
	end

	assign rx_ready = ~rx_shift[0];          // start bit is low
	assign rx_byte  = rx_shift[`PS2_DATA_MSB:`PS2_DATA_LSB];

endmodule

// ==== hdl/ps2_cmd_sender.sv ====
/*
 * Host to device command shifter for the enable-data-reporting frame.
 * Loaded by the sequencer, then shifted one bit per PS/2 clock fall.
 */
`timescale 1ns/1ns
`include "ps2_mouse_defines.svh"

module ps2_cmd_sender
(
	input  logic clk,
	input  logic mrreset,
	input  logic tx_load,      // hold the command frame
	input  logic clk_fall,     // synchronized PS/2 clock fall
	output logic tx_done,      // only the guard bit remains
	output logic ps2_dat_out   // data release level, 0 pulls low
);

	logic [`PS2_CMD_BITS-1:0] tx_shift;  // frame, bit 0 on the line

	// ------------------------------------------------------------------------
	// command shifter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
			tx_shift <= '1;                                   // data released
		else if (tx_load)
			tx_shift <= `PS2_CMD_FRAME;                       // start bit pulls data low
		else if (clk_fall && !tx_done)
			tx_shift <= {1'b0, tx_shift[`PS2_CMD_BITS-1:1]};  // next bit
	end

	assign tx_done     = (tx_shift == `PS2_CMD_DONE);
	assign ps2_dat_out = tx_shift[0];

endmodule

// ==== hdl/mouse_sequencer.sv ====
/*
 * Power-up and packet FSM for the PS/2 mouse, with its timeout timer.
 * Holds the clock low, sends 0xF4, takes the acknowledge, then tags packet bytes.
 */
`timescale 1ns/1ns
`include "ps2_mouse_defines.svh"

module mouse_sequencer
(
	input  logic                    clk,
	input  logic                    mrreset,
	input  logic                    rx_ready,     // full frame received
	input  logic                    tx_done,      // command shifted out
	output logic                    ps2_clk_out,  // clock release level
	output logic                    rx_clear,     // flush receive shifter
	output logic                    tx_load,      // keep command frame loaded
	output ps2_mouse_pkg::pkt_sel_e pkt_sel       // role of the byte in rx_byte
);

	import ps2_mouse_pkg::*;

	mouse_state_e                  state;        // current state
	mouse_state_e                  state_next;   // next state
	logic [`MOUSE_TIMER_BITS-1:0]  timer;        // free running timer
	logic                          timer_clear;  // restart timer
	logic                          timer_full;   // timeout, back to init
	logic                          hold_done;    // clock held low long enough
	logic                          wheel_done;   // no wheel byte coming

	// ------------------------------------------------------------------------
	// timer
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset || timer_clear)
			timer <= '0;
		else
			timer <= timer + 1'b1;
	end

	assign timer_full = &timer;
	assign hold_done  = timer[`MOUSE_HOLD_BIT];
	assign wheel_done = timer[`MOUSE_WHEEL_BIT];

	// ------------------------------------------------------------------------
	// state register, a timeout restarts the whole power-up
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset || timer_full)
			state <= st_init;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next  = state;
		ps2_clk_out = 1'b1;       // clock released by default
		rx_clear    = 1'b0;
		tx_load     = 1'b0;
		timer_clear = 1'b0;
		pkt_sel     = pkt_none;
		case (state)
			st_init:
			begin
				timer_clear = 1'b1;   // start hold-off timing
				state_next  = st_hold_clk;
			end
			st_hold_clk:
			begin
				ps2_clk_out = 1'b0;   // inhibit the mouse
				tx_load     = 1'b1;   // start bit already on data
				if (hold_done)
					state_next = st_send_cmd;
			end
			st_send_cmd:
			begin
				rx_clear = 1'b1;      // ignore our own frame
				if (tx_done)
					state_next = st_wait_ack;
			end
			st_wait_ack:
			begin
				timer_clear = 1'b1;   // mouse may stay silent
				if (rx_ready)
				begin
					rx_clear   = 1'b1;  // drop the acknowledge
					state_next = st_byte1;
				end
			end
			st_byte1:
			begin
				timer_clear = 1'b1;   // idle mouse never times out
				if (rx_ready)
				begin
					pkt_sel    = pkt_buttons;
					rx_clear   = 1'b1;
					state_next = st_byte2;
				end
			end
			st_byte2:
			begin
				if (rx_ready)
				begin
					pkt_sel    = pkt_dx;
					rx_clear   = 1'b1;
					state_next = st_byte3;
				end
			end
			st_byte3:
			begin
				timer_clear = 1'b1;   // wheel wait counts from here
				if (rx_ready)
				begin
					pkt_sel    = pkt_dy;
					rx_clear   = 1'b1;
					state_next = st_byte4;
				end
			end
			st_byte4:
			begin
				if (rx_ready || wheel_done)  // wheel byte or give up on it
				begin
					rx_clear   = 1'b1;        // wheel byte discarded
					state_next = st_byte1;
				end
			end
			default:
				state_next = st_init;
		endcase
	end

endmodule

// ==== hdl/mouse_position.sv ====
/*
 * Button register and wrapping X/Y position counters.
 * Updated from tagged packet bytes; test_load preloads the upper counter bits.
 */
`timescale 1ns/1ns
`include "ps2_mouse_defines.svh"

module mouse_position
(
	input  logic                       clk,
	input  logic                       mrreset,
	input  logic                       test_load,  // preload counters
	input  logic [15:0]                test_data,  // {y[7:2],xx,x[7:2],xx}
	input  ps2_mouse_pkg::pkt_sel_e    pkt_sel,    // which byte is valid
	input  logic [7:0]                 rx_byte,    // received packet byte
	output logic [`MOUSE_BTN_BITS-1:0] btn,        // {middle, right, left}
	output logic [7:0]                 x_count,    // X position, wraps
	output logic [7:0]                 y_count     // Y position, wraps
);

	import ps2_mouse_pkg::*;

	// ------------------------------------------------------------------------
	// accumulator where preload wins over packet bytes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			btn     <= '0;
			x_count <= 8'h00;
			y_count <= 8'h00;
		end
		else if (test_load)
		begin
			y_count[7:2] <= test_data[15:10];  // low bits kept
			x_count[7:2] <= test_data[7:2];
		end
		else
		begin
			case (pkt_sel)
				pkt_buttons:
					btn <= rx_byte[`MOUSE_BTN_BITS-1:0];
				pkt_dx:
					x_count <= x_count + rx_byte;  // mod 256
				pkt_dy:
					y_count <= y_count - rx_byte;  // PS/2 y grows upward
				default:
					;                              // pkt_none holds
			endcase
		end
	end

endmodule

// ==== hdl/ps2_mouse_top.sv ====
/*
 * PS/2 mouse controller top level.
 * Open-collector release outputs for clock and data, the board forms the wired-AND.
 */
`timescale 1ns/1ns
`include "ps2_mouse_defines.svh"

module ps2_mouse_top
(
	input  logic                       clk,
	input  logic                       mrreset,
	input  logic                       ps2_clk_in,   // PS/2 clock pin
	input  logic                       ps2_dat_in,   // PS/2 data pin
	input  logic                       test_load,    // counter preload strobe
	input  logic [15:0]                test_data,    // counter preload value
	output logic                       ps2_clk_out,  // 1 releases clock
	output logic                       ps2_dat_out,  // 1 releases data
	output logic [`MOUSE_BTN_BITS-1:0] btn,
	output logic [7:0]                 x_count,
	output logic [7:0]                 y_count
);

	import ps2_mouse_pkg::*;

	logic       clk_fall;  // PS/2 clock fall strobe
	logic       rx_ready;  // frame waiting
	logic [7:0] rx_byte;   // frame data
	logic       rx_clear;  // flush receiver
	logic       tx_load;   // command frame load
	logic       tx_done;   // command sent
	pkt_sel_e   pkt_sel;   // byte tag to accumulator

	// ------------------------------------------------------------------------
	// input side
	// ------------------------------------------------------------------------
	ps2_rx_shifter i_ps2_rx_shifter
	(
		.clk        (clk),
		.mrreset    (mrreset),
		.ps2_clk_in (ps2_clk_in),
		.ps2_dat_in (ps2_dat_in),
		.rx_clear   (rx_clear),
		.clk_fall   (clk_fall),
		.rx_ready   (rx_ready),
		.rx_byte    (rx_byte)
	);

	// command out and sequencing
	ps2_cmd_sender i_ps2_cmd_sender
	(
		.clk         (clk),
		.mrreset     (mrreset),
		.tx_load     (tx_load),
		.clk_fall    (clk_fall),
		.tx_done     (tx_done),
		.ps2_dat_out (ps2_dat_out)
	);

	mouse_sequencer i_mouse_sequencer
	(
		.clk         (clk),
		.mrreset     (mrreset),
		.rx_ready    (rx_ready),
		.tx_done     (tx_done),
		.ps2_clk_out (ps2_clk_out),
		.rx_clear    (rx_clear),
		.tx_load     (tx_load),
		.pkt_sel     (pkt_sel)
	);

	// output side
	mouse_position i_mouse_position
	(
		.clk       (clk),
		.mrreset   (mrreset),
		.test_load (test_load),
		.test_data (test_data),
		.pkt_sel   (pkt_sel),
		.rx_byte   (rx_byte),
		.btn       (btn),
		.x_count   (x_count),
		.y_count   (y_count)
	);

endmodule

// ==== testbench/tb_ps2_mouse.sv ====
/*
 * Testbench for the PS/2 mouse controller with a mouse model on the wired-AND lines,
 * a reference model of the counters and a compare process.
 */
`timescale 1ns/1ns
`include "ps2_mouse_defines.svh"

module tb_ps2_mouse;

	localparam int HALF_BIT       = 20;      // system cycles per PS/2 half period
	localparam int TIMEOUT_CYCLES = 400000;  // init, 43 packets, two wheel waits
	localparam int NUM_PACKETS    = 40;
	localparam int WHEEL_WAIT     = 17000;   // longer than the wheel byte wait
	localparam logic [1:0] OP_BTN  = 2'd0;
	localparam logic [1:0] OP_DX   = 2'd1;
	localparam logic [1:0] OP_DY   = 2'd2;
	localparam logic [1:0] OP_LOAD = 2'd3;

	logic        clk;
	logic        mrreset;
	logic        dev_clk;        // mouse model clock drive
	logic        dev_dat;        // mouse model data drive
	logic        ps2_clk_in;
	logic        ps2_dat_in;
	logic        test_load;
	logic [15:0] test_data;
	logic        ps2_clk_out;
	logic        ps2_dat_out;
	logic [2:0]  btn;
	logic [7:0]  x_count;
	logic [7:0]  y_count;

	logic [31:0] seed;           // LCG state
	logic [18:0] exp_state;      // {btn, x, y} reference
	logic        init_done;      // clock must stay released from here
	int          cycle_count;
	int          pkt;
	logic [7:0]  r_head;
	logic [7:0]  r_dx;
	logic [7:0]  r_dy;
	logic [7:0]  r_wheel;
	event        check_ev;

	// open-collector lines
	assign ps2_clk_in = dev_clk & ps2_clk_out;
	assign ps2_dat_in = dev_dat & ps2_dat_out;

	ps2_mouse_top i_ps2_mouse_top
	(
		.clk         (clk),
		.mrreset     (mrreset),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_dat_in  (ps2_dat_in),
		.test_load   (test_load),
		.test_data   (test_data),
		.ps2_clk_out (ps2_clk_out),
		.ps2_dat_out (ps2_dat_out),
		.btn         (btn),
		.x_count     (x_count),
		.y_count     (y_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;      // 8 ns period
	end

	// ------------------------------------------------------------------------
	// failure reporting and compare
	// ------------------------------------------------------------------------
	task halt_failed();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task report_error(input string reason);
		$display("ERROR at %0t ns: %s", $time, reason);
		halt_failed();
	endtask

	task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
			halt_failed();
		end
	endtask

	// counters after one tagged byte or a preload
	function automatic logic [18:0] ref_model(input logic [18:0] cur, input logic [1:0] op,
		input logic [15:0] val);
		logic [2:0] b;
		logic [7:0] x;
		logic [7:0] y;
		{b, x, y} = cur;
		case (op)
			OP_BTN:  b = val[2:0];           // low three bits of byte 1
			OP_DX:   x = x + val[7:0];       // wraps mod 256
			OP_DY:   y = y - val[7:0];       // y counts down
			default:
			begin
				x = {val[7:2], x[1:0]};      // upper six bits loaded
				y = {val[15:10], y[1:0]};
			end
		endcase
		return {b, x, y};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task rand_byte(output logic [7:0] b);
		seed = lcg_next(seed);
		b    = seed[23:16];              // upper bits spread better
	endtask

	// compare process fired once per finished packet
	always
	begin
		@(check_ev);
		check_value("btn", exp_state[18:16], btn);
		check_value("x_count", exp_state[15:8], x_count);
		check_value("y_count", exp_state[7:0], y_count);
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_error("simulation ran past its cycle limit");
	end

	always @(negedge clk)
		if (init_done && ps2_clk_out !== 1'b1)
			report_error("PS/2 clock pulled low again, controller reinitialized");

	// ------------------------------------------------------------------------
	// mouse model
	// ------------------------------------------------------------------------
	task wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task request_check();
		-> check_ev;
	endtask

	// device to host frame with data set while clock is high
	task send_byte(input logic [7:0] b);
		logic [`PS2_FRAME_BITS-1:0] frame;
		int                          i;
		frame = {1'b1, ~^b, b, 1'b0};   // stop, odd parity, data, start
		for (i = 0; i < `PS2_FRAME_BITS; i++)
		begin
			dev_dat = frame[i];
			wait_cycles(HALF_BIT / 2);
			dev_clk = 1'b0;             // host samples on this fall
			wait_cycles(HALF_BIT);
			dev_clk = 1'b1;
			wait_cycles(HALF_BIT / 2);
		end
		dev_dat = 1'b1;
	endtask

	task send_packet(input logic [7:0] head, input logic [7:0] dx, input logic [7:0] dy,
		input logic [7:0] wheel, input bit with_wheel);
		send_byte(head);
		send_byte(dx);
		send_byte(dy);
		if (with_wheel)
			send_byte(wheel);            // must change nothing
		exp_state = ref_model(exp_state, OP_BTN, {8'h00, head});
		exp_state = ref_model(exp_state, OP_DX, {8'h00, dx});
		exp_state = ref_model(exp_state, OP_DY, {8'h00, dy});
		wait_cycles(10);
		request_check();
	endtask

	// wait for hold-off and release then clock the host command in
	task capture_command();
		logic [`PS2_FRAME_BITS-1:0] bits;
		logic [7:0]                  cmd;
		int                          n;
		int                          i;
		cmd = 8'hF4;
		n   = 0;
		while (ps2_clk_out !== 1'b0)
		begin
			wait_cycles(1);
			n++;
			if (n > 100)
				report_error("PS/2 clock was never held low after reset");
		end
		n = 0;
		while (ps2_clk_out !== 1'b1)
		begin
			wait_cycles(1);
			n++;
			if (n > 4096)
				report_error("PS/2 clock was never released after the hold-off");
		end
		wait_cycles(HALF_BIT);
		if (ps2_dat_out !== 1'b0)
			report_error("no command start bit on data after clock release");
		for (i = 0; i < `PS2_FRAME_BITS; i++)
		begin
			bits[i] = ps2_dat_out;      // read just before each fall
			dev_clk = 1'b0;
			wait_cycles(HALF_BIT);
			dev_clk = 1'b1;
			wait_cycles(HALF_BIT);
		end
		check_value("command frame", {1'b1, ~^cmd, cmd, 1'b0}, bits);
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial
	begin
		mrreset     = 1'b1;
		dev_clk     = 1'b1;
		dev_dat     = 1'b1;
		test_load   = 1'b0;
		test_data   = 16'h0000;
		seed        = 32'd37375;
		exp_state   = '0;
		init_done   = 1'b0;
		cycle_count = 0;
		wait_cycles(2);               // reset for 2 cycles
		mrreset = 1'b0;

		capture_command();
		init_done = 1'b1;
		wait_cycles(HALF_BIT);
		send_byte(`PS2_ACK_BYTE);
		wait_cycles(10);
		request_check();              // acknowledge is no delta

		for (pkt = 0; pkt < NUM_PACKETS; pkt++)
		begin
			rand_byte(r_head);
			rand_byte(r_dx);
			rand_byte(r_dy);
			rand_byte(r_wheel);
			send_packet(r_head | 8'h08, r_dx, r_dy, r_wheel, 1'b1);
		end

		// two 3-byte packets each followed by the wheel wait
		for (pkt = 0; pkt < 2; pkt++)
		begin
			rand_byte(r_head);
			rand_byte(r_dx);
			rand_byte(r_dy);
			send_packet(r_head | 8'h08, r_dx, r_dy, 8'h00, 1'b0);
			wait_cycles(WHEEL_WAIT);
		end

		// preload then accumulate from it
		rand_byte(r_dx);
		rand_byte(r_dy);
		test_data = {r_dy, r_dx};
		test_load = 1'b1;
		wait_cycles(1);
		test_load = 1'b0;
		exp_state = ref_model(exp_state, OP_LOAD, test_data);
		wait_cycles(2);
		request_check();
		rand_byte(r_head);
		rand_byte(r_dx);
		rand_byte(r_dy);
		rand_byte(r_wheel);
		send_packet(r_head | 8'h08, r_dx, r_dy, r_wheel, 1'b1);

		wait_cycles(20);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
hdl/ps2_mouse_pkg.sv
hdl/ps2_rx_shifter.sv
hdl/ps2_cmd_sender.sv
hdl/mouse_sequencer.sv
hdl/mouse_position.sv
hdl/ps2_mouse_top.sv
testbench/tb_ps2_mouse.sv
